/* hdl/lsu_pkg.sv */
package lsu_pkg;

  // data and address vectors
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0] strb_t;  // one bit per byte lane

  // load/store operation encoding from the decode stage
  typedef enum logic [2:0] {
    op_lb,
    op_lbu,
    op_lh,
    op_lhu,
    op_lw,
    op_sb,
    op_sh,
    op_sw
  } lsu_op_t;

endpackage

/* hdl/soc_map_pkg.sv */
package soc_map_pkg;

  // cacheable regions, limit is exclusive
  parameter logic [31:0] mrom_base   = 32'h2000_0000;
  parameter logic [31:0] mrom_limit  = 32'h2040_0000;

  parameter logic [31:0] flash_base  = 32'h3000_0000;
  parameter logic [31:0] flash_limit = 32'h4000_0000;

  parameter logic [31:0] psram_base  = 32'h8000_0000;
  parameter logic [31:0] psram_limit = 32'h8800_0000;

  parameter logic [31:0] sdram_base  = 32'ha000_0000;
  parameter logic [31:0] sdram_limit = 32'hc000_0000;

endpackage

/* hdl/lsu_bus_if.sv */
`timescale 1ns/1ps

interface lsu_bus_if;
  import lsu_pkg::*;

  // read channel
  logic  arvalid;
  addr_t araddr;
  strb_t rstrb;
  logic  rvalid;  // one cycle response
  word_t rdata;

  // write channel
  logic  awvalid;
  addr_t awaddr;
  word_t wdata;
  strb_t wstrb;
  logic  bvalid;

  modport rd_master (
    output arvalid, araddr, rstrb,
    input  rvalid, rdata
  );

  modport wr_master (
    output awvalid, awaddr, wdata, wstrb,
    input  bvalid
  );

  modport slave (
    input  arvalid, araddr, rstrb, awvalid, awaddr, wdata, wstrb,
    output rvalid, rdata, bvalid
  );
endinterface

/* hdl/lsu_l1d.sv */
`timescale 1ns/1ps

module lsu_l1d #(
  parameter int l1d_index_bits = 4
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             flush_pipe,
  input  logic             invalid_l1d,
  input  lsu_pkg::addr_t   raddr,
  input  logic             rvalid,
  input  lsu_pkg::lsu_op_t rop,
  input  lsu_pkg::addr_t   waddr,
  input  logic             wvalid,
  input  logic             wready,
  input  lsu_pkg::word_t   wdata,
  input  lsu_pkg::lsu_op_t wop,
  output lsu_pkg::word_t   rdata_word,
  output logic             rready,
  lsu_bus_if.rd_master     bus
);
  import lsu_pkg::*;
  import soc_map_pkg::*;

  localparam int lines = 1 << l1d_index_bits;
  localparam int tag_bits = 32 - l1d_index_bits - 2;

  typedef logic [l1d_index_bits-1:0] index_t;
  typedef logic [tag_bits-1:0] tag_t;

  typedef enum logic [1:0] {
    st_idle,
    st_fill,
    st_deliver
  } state_t;

  state_t state;

  word_t            data_mem [lines];
  tag_t             tag_mem [lines];
  logic [lines-1:0] valid_mem;

  addr_t   fill_addr;
  lsu_op_t fill_op;
  word_t   fill_buf;
  logic    fill_cacheable;
  logic    fill_write;

  index_t rd_idx;
  tag_t   rd_tag;
  logic   rd_hit;
  index_t wr_idx;
  tag_t   wr_tag;
  logic   wr_hit;

  logic store_accept;
  logic store_full;
  logic store_inval;

  // pending array update for the next cycle
  logic   upd_en;
  index_t upd_idx;
  tag_t   upd_tag;
  word_t  upd_data;
  logic   upd_valid;

  function automatic logic is_cacheable(addr_t a);
    return (a >= mrom_base && a < mrom_limit) ||
           (a >= flash_base && a < flash_limit) ||
           (a >= psram_base && a < psram_limit) ||
           (a >= sdram_base && a < sdram_limit);
  endfunction

  function automatic strb_t size_strb(lsu_op_t op);
    case (op)
      op_lb, op_lbu: return 4'b0001;
      op_lh, op_lhu: return 4'b0011;
      default:       return 4'b1111;
    endcase
  endfunction

  assign rd_idx = raddr[l1d_index_bits+1:2];
  assign rd_tag = raddr[31:l1d_index_bits+2];
  assign rd_hit = valid_mem[rd_idx] && (tag_mem[rd_idx] == rd_tag);

  assign wr_idx = waddr[l1d_index_bits+1:2];
  assign wr_tag = waddr[31:l1d_index_bits+2];
  assign wr_hit = valid_mem[wr_idx] && (tag_mem[wr_idx] == wr_tag);

  assign rdata_word = (state == st_deliver) ? fill_buf : data_mem[rd_idx];
  assign rready = rvalid && ((state == st_idle && rd_hit) || state == st_deliver);

  // cacheable misses fetch the whole word
  assign fill_cacheable = is_cacheable(fill_addr);
  assign bus.arvalid = (state == st_fill);
  assign bus.araddr = fill_cacheable ? {fill_addr[31:2], 2'b00} : fill_addr;
  assign bus.rstrb = fill_cacheable ? 4'b1111 : size_strb(fill_op);

  assign fill_write = (state == st_fill) && bus.rvalid && fill_cacheable;
  assign store_accept = wvalid && wready && is_cacheable(waddr);
  assign store_full = store_accept && (wop == op_sw);
  assign store_inval = store_accept && (wop != op_sw) && wr_hit;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (!flush_pipe && rvalid && !rd_hit) begin
            state <= st_fill;
          end
        end
        st_fill: begin
          if (bus.rvalid) begin
            state <= st_deliver;
          end
        end
        default: state <= st_idle;  // deliver lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle && rvalid) begin
      fill_addr <= raddr;
      fill_op   <= rop;
    end
    if (bus.rvalid) begin
      fill_buf <= bus.rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      upd_en <= 1'b0;
    end else begin
      upd_en <= store_full || store_inval || fill_write;
    end
  end

  always_ff @(posedge clock) begin
    if (store_full) begin  // write-through keeps the line
      upd_idx   <= wr_idx;
      upd_tag   <= wr_tag;
      upd_data  <= wdata;
      upd_valid <= 1'b1;
    end else if (store_inval) begin
      upd_idx   <= wr_idx;
      upd_tag   <= wr_tag;
      upd_valid <= 1'b0;
    end else if (fill_write) begin
      upd_idx   <= fill_addr[l1d_index_bits+1:2];
      upd_tag   <= fill_addr[31:l1d_index_bits+2];
      upd_data  <= bus.rdata;
      upd_valid <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || invalid_l1d) begin
      valid_mem <= '0;
    end else if (upd_en) begin
      valid_mem[upd_idx] <= upd_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (upd_en) begin
      data_mem[upd_idx] <= upd_data;
      tag_mem[upd_idx]  <= upd_tag;
    end
  end

  // read response only while a fill is outstanding
  a_resp_in_fill: assert property (@(posedge clock) disable iff (reset)
    bus.rvalid |-> state == st_fill);

  // core holds the load until it is delivered
  a_deliver_held: assert property (@(posedge clock) disable iff (reset)
    state == st_deliver |-> rvalid);
endmodule

/* hdl/lsu_store.sv */
`timescale 1ns/1ps

module lsu_store (
  input  logic             clock,
  input  logic             reset,
  input  lsu_pkg::addr_t   waddr,
  input  logic             wvalid,
  input  lsu_pkg::word_t   wdata,
  input  lsu_pkg::lsu_op_t wop,
  output logic             wready,
  lsu_bus_if.wr_master     bus
);
  import lsu_pkg::*;

  logic       awvalid_q;
  addr_t      awaddr_q;
  word_t      wdata_q;
  strb_t      wstrb_q;
  strb_t      strb;
  logic [4:0] lane_shift;

  assign lane_shift = {waddr[1:0], 3'b000};

  always_comb begin
    case (wop)
      op_sb:   strb = 4'b0001 << waddr[1:0];
      op_sh:   strb = 4'b0011 << {waddr[1], 1'b0};
      default: strb = 4'b1111;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      awvalid_q <= 1'b0;
    end else if (bus.bvalid) begin
      awvalid_q <= 1'b0;
    end else if (wvalid && !awvalid_q) begin
      awvalid_q <= 1'b1;
    end
  end

  // capture one store, low bytes moved to their lanes
  always_ff @(posedge clock) begin
    if (wvalid && !awvalid_q) begin
      awaddr_q <= waddr;
      wdata_q  <= wdata << lane_shift;
      wstrb_q  <= strb;
    end
  end

  assign bus.awvalid = awvalid_q;
  assign bus.awaddr = awaddr_q;
  assign bus.wdata = wdata_q;
  assign bus.wstrb = wstrb_q;
  assign wready = bus.bvalid;  // core drops wvalid next cycle

  a_aw_hold: assert property (@(posedge clock) disable iff (reset)
    bus.awvalid && !bus.bvalid |=> bus.awvalid && $stable(bus.awaddr));
endmodule

/* hdl/lsu_load_align.sv */
`timescale 1ns/1ps

module lsu_load_align (
  input  lsu_pkg::word_t   rdata_word,
  input  lsu_pkg::addr_t   raddr,
  input  lsu_pkg::lsu_op_t rop,
  output lsu_pkg::word_t   rdata
);
  import lsu_pkg::*;

  word_t       shifted;
  logic [7:0]  byte_v;
  logic [15:0] half_v;

  // selected lane down to bit 0
  assign shifted = rdata_word >> {raddr[1:0], 3'b000};
  assign byte_v = shifted[7:0];
  assign half_v = shifted[15:0];

  always_comb begin
    case (rop)
      op_lb:   rdata = {{24{byte_v[7]}}, byte_v};
      op_lbu:  rdata = {24'b0, byte_v};
      op_lh:   rdata = {{16{half_v[15]}}, half_v};
      op_lhu:  rdata = {16'b0, half_v};
      default: rdata = rdata_word;  // lw
    endcase
  end
endmodule

/* hdl/lsu_apb_bridge.sv */
`timescale 1ns/1ps

module lsu_apb_bridge (
  input  logic           clock,
  input  logic           reset,
  output logic           psel,
  output logic           penable,
  output logic           pwrite,
  output lsu_pkg::addr_t paddr,
  output lsu_pkg::word_t pwdata,
  output lsu_pkg::strb_t pstrb,
  input  lsu_pkg::word_t prdata,
  input  logic           pready,
  lsu_bus_if.slave       bus
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    apb_idle,
    apb_setup,
    apb_access
  } apb_state_t;

  apb_state_t state;
  logic       rvalid_q;
  logic       bvalid_q;
  word_t      rdata_q;
  logic       resp_busy;
  logic       start;

  // requester still holds its request during the response pulse
  assign resp_busy = rvalid_q || bvalid_q;
  assign start = (state == apb_idle) && !resp_busy && (bus.awvalid || bus.arvalid);

  assign psel = (state != apb_idle);
  assign penable = (state == apb_access);

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= apb_idle;
      pwrite   <= 1'b0;
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
      case (state)
        apb_idle: begin
          if (start) begin
            state  <= apb_setup;
            pwrite <= bus.awvalid;  // writes first
          end
        end
        apb_setup: state <= apb_access;
        default: begin
          if (pready) begin
            state    <= apb_idle;
            rvalid_q <= !pwrite;
            bvalid_q <= pwrite;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      paddr  <= bus.awvalid ? bus.awaddr : bus.araddr;
      pwdata <= bus.awvalid ? bus.wdata : '0;
      pstrb  <= bus.awvalid ? bus.wstrb : '0;  // zero on reads
    end
    if (state == apb_access && pready) begin
      rdata_q <= prdata;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.bvalid = bvalid_q;
  assign bus.rdata = rdata_q;

  a_setup_first: assert property (@(posedge clock) disable iff (reset)
    $rose(penable) |-> $past(psel && !penable));

  a_paddr_stable: assert property (@(posedge clock) disable iff (reset)
    penable |-> $stable(paddr) && $stable(pwrite));

  a_read_strb: assert property (@(posedge clock) disable iff (reset)
    bus.arvalid |-> bus.rstrb != '0);
endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top #(
  parameter int l1d_index_bits = 4
) (
  input  logic             clock,
  input  logic             reset,
  input  lsu_pkg::addr_t   raddr,
  input  logic             rvalid,
  input  lsu_pkg::lsu_op_t rop,
  output lsu_pkg::word_t   rdata,
  output logic             rready,
  input  lsu_pkg::addr_t   waddr,
  input  logic             wvalid,
  input  lsu_pkg::word_t   wdata,
  input  lsu_pkg::lsu_op_t wop,
  output logic             wready,
  input  logic             flush_pipe,
  input  logic             invalid_l1d,
  output logic             psel,
  output logic             penable,
  output logic             pwrite,
  output lsu_pkg::addr_t   paddr,
  output lsu_pkg::word_t   pwdata,
  output lsu_pkg::strb_t   pstrb,
  input  lsu_pkg::word_t   prdata,
  input  logic             pready
);
  import lsu_pkg::*;

  word_t rdata_word;  // raw word before alignment

  lsu_bus_if bus ();

  lsu_l1d #(
    .l1d_index_bits(l1d_index_bits)
  ) l1d_i (
    .clock      (clock),
    .reset      (reset),
    .flush_pipe (flush_pipe),
    .invalid_l1d(invalid_l1d),
    .raddr      (raddr),
    .rvalid     (rvalid),
    .rop        (rop),
    .waddr      (waddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wop        (wop),
    .rdata_word (rdata_word),
    .rready     (rready),
    .bus        (bus)
  );

  lsu_store store_i (
    .clock (clock),
    .reset (reset),
    .waddr (waddr),
    .wvalid(wvalid),
    .wdata (wdata),
    .wop   (wop),
    .wready(wready),
    .bus   (bus)
  );

  lsu_load_align align_i (
    .rdata_word(rdata_word),
    .raddr     (raddr),
    .rop       (rop),
    .rdata     (rdata)
  );

  lsu_apb_bridge bridge_i (
    .clock  (clock),
    .reset  (reset),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .pstrb  (pstrb),
    .prdata (prdata),
    .pready (pready),
    .bus    (bus)
  );
endmodule

/* dv/lsu_checker.sv */
`timescale 1ns/1ps

module lsu_checker (
  input  logic           clock,
  input  logic           reset,
  input  logic           rready,
  input  lsu_pkg::word_t rdata,
  input  logic           wready,
  input  logic           psel,
  input  logic           penable,
  input  logic           pwrite,
  input  logic           pready,
  input  lsu_pkg::addr_t paddr,
  input  lsu_pkg::strb_t pstrb,
  input  logic [127:0]   name,
  input  lsu_pkg::word_t exp_data,
  input  lsu_pkg::addr_t exp_paddr,
  input  lsu_pkg::strb_t exp_pstrb,
  input  int             exp_reads,
  input  int             exp_writes,
  input  logic           entry_end,
  input  logic           all_done,
  output int             fail_count
);
  import lsu_pkg::*;

  int   apb_reads;
  int   apb_writes;
  int   handshakes;
  int   pass_count;
  logic entry_bad;

  task automatic mismatch(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
    $display("[ERROR] %0s: %0s expected 0x%0h, actual 0x%0h", name, what, expected, actual);
    entry_bad = 1'b1;
  endtask

  // inputs sampled at the rising edge before its updates land
  always @(posedge clock) begin
    if (reset) begin
      apb_reads = 0;
      apb_writes = 0;
      handshakes = 0;
      pass_count = 0;
      fail_count = 0;
      entry_bad = 1'b0;
    end else begin
      if (rready) begin
        handshakes++;
        if (rdata !== exp_data) mismatch("load data", exp_data, rdata);
      end
      if (wready) handshakes++;
      if (psel && penable && pready) begin  // transfer ends here
        if (pwrite) begin
          apb_writes++;
        end else begin
          apb_reads++;
        end
        if (pstrb !== exp_pstrb) mismatch("pstrb", exp_pstrb, pstrb);
        if (paddr !== exp_paddr) mismatch("paddr", exp_paddr, paddr);
      end
      if (entry_end) begin
        if (apb_reads != exp_reads) mismatch("apb reads", exp_reads, apb_reads);
        if (apb_writes != exp_writes) mismatch("apb writes", exp_writes, apb_writes);
        if (handshakes != 1) begin
          $display("%0s: expected one handshake with the core, saw %0d", name, handshakes);
          entry_bad = 1'b1;
        end
        if (entry_bad) begin
          fail_count++;
          $display("%0s: failed", name);
        end else begin
          pass_count++;
          $display("%0s: ok", name);
        end
        apb_reads = 0;
        apb_writes = 0;
        handshakes = 0;
        entry_bad = 1'b0;
      end
      if (all_done) begin
        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
      end
    end
  end
endmodule

/* dv/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;
  import lsu_pkg::*;
  import soc_map_pkg::*;

  localparam int max_entries = 48;
  localparam int reset_cycles = 8;

  typedef struct packed {
    logic [127:0] name;
    lsu_op_t      op;
    addr_t        addr;
    word_t        data;
    word_t        exp_data;
    addr_t        paddr;
    strb_t        strb;
    int           reads;
    int           writes;
    logic         inval;  // pulse invalid_l1d first
  } entry_t;

  logic    clock;
  logic    reset;
  addr_t   raddr;
  logic    rvalid;
  lsu_op_t rop;
  word_t   rdata;
  logic    rready;
  addr_t   waddr;
  logic    wvalid;
  word_t   wdata;
  lsu_op_t wop;
  logic    wready;
  logic    flush_pipe;
  logic    invalid_l1d;
  logic    psel;
  logic    penable;
  logic    pwrite;
  addr_t   paddr;
  word_t   pwdata;
  strb_t   pstrb;
  word_t   prdata;
  logic    pready;

  logic [127:0] cur_name;
  word_t        exp_data;
  addr_t        exp_paddr;
  strb_t        exp_pstrb;
  int           exp_reads;
  int           exp_writes;
  logic         entry_end;
  logic         all_done;
  int           fail_count;

  entry_t      stim [max_entries];
  int          n_entries;
  word_t       apb_mem [logic [29:0]];
  word_t       model_mem [logic [29:0]];
  logic [31:0] rng;
  int          wait_left;

  lsu_top #(.l1d_index_bits(4)) dut_i (
    .clock(clock), .reset(reset),
    .raddr(raddr), .rvalid(rvalid), .rop(rop), .rdata(rdata), .rready(rready),
    .waddr(waddr), .wvalid(wvalid), .wdata(wdata), .wop(wop), .wready(wready),
    .flush_pipe(flush_pipe), .invalid_l1d(invalid_l1d),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready)
  );

  lsu_checker checker_i (
    .clock(clock), .reset(reset), .rready(rready), .rdata(rdata), .wready(wready),
    .psel(psel), .penable(penable), .pwrite(pwrite), .pready(pready),
    .paddr(paddr), .pstrb(pstrb), .name(cur_name), .exp_data(exp_data),
    .exp_paddr(exp_paddr), .exp_pstrb(exp_pstrb), .exp_reads(exp_reads),
    .exp_writes(exp_writes), .entry_end(entry_end), .all_done(all_done),
    .fail_count(fail_count)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // power-up content of a word depends on all address bits above the byte lane
  function automatic word_t init_word(input addr_t a);
    return lcg_next({2'b00, a[31:2]});
  endfunction

  function automatic word_t apb_read(input addr_t a);
    return apb_mem.exists(a[31:2]) ? apb_mem[a[31:2]] : init_word(a);
  endfunction

  function automatic word_t model_read(input addr_t a);
    return model_mem.exists(a[31:2]) ? model_mem[a[31:2]] : init_word(a);
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t lanes, input strb_t strb);
    word_t r;
    r = old;
    for (int k = 0; k < 4; k++) begin
      if (strb[k]) r[8*k +: 8] = lanes[8*k +: 8];
    end
    return r;
  endfunction

  function automatic logic in_region(input addr_t a, input addr_t base, input addr_t limit);
    return a >= base && a < limit;
  endfunction

  function automatic logic cached_region(input addr_t a);
    return in_region(a, mrom_base, mrom_limit) || in_region(a, flash_base, flash_limit) ||
           in_region(a, psram_base, psram_limit) || in_region(a, sdram_base, sdram_limit);
  endfunction

  function automatic logic is_store(input lsu_op_t op);
    return op == op_sb || op == op_sh || op == op_sw;
  endfunction

  function automatic strb_t store_strobe(input lsu_op_t op, input logic [1:0] off);
    case (op)
      op_sb:   return 4'b0001 << off;
      op_sh:   return off[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic word_t extend_load(input word_t w, input lsu_op_t op, input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[8*off +: 8];
    h = off[1] ? w[31:16] : w[15:0];
    case (op)
      op_lb:   return {{24{b[7]}}, b};
      op_lbu:  return {24'h0, b};
      op_lh:   return {{16{h[15]}}, h};
      op_lhu:  return {16'h0, h};
      default: return w;
    endcase
  endfunction

  // expected values follow a shadow memory updated in table order
  task automatic add_entry(input logic [127:0] name, input lsu_op_t op, input addr_t addr,
                           input word_t data, input int reads, input logic inval);
    entry_t e;
    e.name = name;
    e.op = op;
    e.addr = addr;
    e.data = data;
    e.reads = reads;
    e.inval = inval;
    if (is_store(op)) begin
      e.strb = store_strobe(op, addr[1:0]);
      e.paddr = addr;
      e.exp_data = '0;
      e.writes = 1;
      model_mem[addr[31:2]] = merge_bytes(model_read(addr), data << (8 * addr[1:0]), e.strb);
    end else begin
      e.strb = '0;
      e.paddr = cached_region(addr) ? {addr[31:2], 2'b00} : addr;
      e.exp_data = extend_load(model_read(addr), op, addr[1:0]);
      e.writes = 0;
    end
    stim[n_entries] = e;
    n_entries++;
  endtask

  task automatic build_table();
    add_entry("psram_miss", op_lw, 32'h8000_0010, 32'h0, 1, 1'b0);
    add_entry("psram_hit", op_lw, 32'h8000_0010, 32'h0, 0, 1'b0);
    add_entry("lb_off0_miss", op_lb, 32'h8000_0020, 32'h0, 1, 1'b0);
    add_entry("lb_off1", op_lb, 32'h8000_0021, 32'h0, 0, 1'b0);
    add_entry("lb_off2", op_lb, 32'h8000_0022, 32'h0, 0, 1'b0);
    add_entry("lb_off3", op_lb, 32'h8000_0023, 32'h0, 0, 1'b0);
    add_entry("lbu_off0", op_lbu, 32'h8000_0020, 32'h0, 0, 1'b0);
    add_entry("lbu_off1", op_lbu, 32'h8000_0021, 32'h0, 0, 1'b0);
    add_entry("lbu_off2", op_lbu, 32'h8000_0022, 32'h0, 0, 1'b0);
    add_entry("lbu_off3", op_lbu, 32'h8000_0023, 32'h0, 0, 1'b0);
    add_entry("lh_off0", op_lh, 32'h8000_0020, 32'h0, 0, 1'b0);
    add_entry("lh_off2", op_lh, 32'h8000_0022, 32'h0, 0, 1'b0);
    add_entry("lhu_off0", op_lhu, 32'h8000_0020, 32'h0, 0, 1'b0);
    add_entry("lhu_off2", op_lhu, 32'h8000_0022, 32'h0, 0, 1'b0);
    add_entry("lw_ext", op_lw, 32'h8000_0020, 32'h0, 0, 1'b0);
    add_entry("sw_through", op_sw, 32'h8000_0040, 32'h1234_5678, 0, 1'b0);
    add_entry("lw_after_sw", op_lw, 32'h8000_0040, 32'h0, 0, 1'b0);
    add_entry("sb_inval", op_sb, 32'h8000_0041, 32'h0000_00ab, 0, 1'b0);
    add_entry("lw_after_sb", op_lw, 32'h8000_0040, 32'h0, 1, 1'b0);
    add_entry("sh_sdram", op_sh, 32'ha000_0006, 32'h0000_beef, 0, 1'b0);
    add_entry("lhu_sdram", op_lhu, 32'ha000_0006, 32'h0, 1, 1'b0);
    add_entry("io_lb_a", op_lb, 32'h1000_0003, 32'h0, 1, 1'b0);
    add_entry("io_lb_b", op_lb, 32'h1000_0003, 32'h0, 1, 1'b0);
    add_entry("io_lw", op_lw, 32'h1000_0000, 32'h0, 1, 1'b0);
    add_entry("conflict_a0", op_lw, 32'h8000_0030, 32'h0, 1, 1'b0);
    add_entry("conflict_b0", op_lw, 32'h8000_0070, 32'h0, 1, 1'b0);
    add_entry("conflict_a1", op_lw, 32'h8000_0030, 32'h0, 1, 1'b0);
    add_entry("conflict_b1", op_lw, 32'h8000_0070, 32'h0, 1, 1'b0);
    add_entry("pre_inval_hit", op_lw, 32'h8000_0010, 32'h0, 0, 1'b0);
    add_entry("inval_reload", op_lw, 32'h8000_0010, 32'h0, 1, 1'b1);
    add_entry("post_inval_hit", op_lw, 32'h8000_0010, 32'h0, 0, 1'b0);
  endtask

  task automatic run_entry(input entry_t e);
    @(posedge clock);
    cur_name <= e.name;
    exp_data <= e.exp_data;
    exp_paddr <= e.paddr;
    exp_pstrb <= e.strb;
    exp_reads <= e.reads;
    exp_writes <= e.writes;
    if (e.inval) begin
      invalid_l1d <= 1'b1;
      @(posedge clock);
      invalid_l1d <= 1'b0;
      @(posedge clock);
    end
    if (is_store(e.op)) begin
      waddr <= e.addr;
      wdata <= e.data;
      wop <= e.op;
      wvalid <= 1'b1;
    end else begin
      raddr <= e.addr;
      rop <= e.op;
      rvalid <= 1'b1;
    end
    do begin
      @(posedge clock);
    end while (!(rready || wready));  // held until acknowledged
    rvalid <= 1'b0;
    wvalid <= 1'b0;
    repeat (2) @(posedge clock);
    entry_end <= 1'b1;
    @(posedge clock);
    entry_end <= 1'b0;
  endtask

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // apb slave, 0 to 3 wait states per access
  always @(posedge clock) begin
    if (reset) begin
      pready <= 1'b0;
      wait_left = 0;
    end else if (pready) begin
      pready <= 1'b0;
      if (pwrite) apb_mem[paddr[31:2]] = merge_bytes(apb_read(paddr), pwdata, pstrb);
    end else if (psel && (!penable || wait_left > 0)) begin
      if (!penable) begin
        rng = lcg_next(rng);
        wait_left = rng[31:30];
      end else begin
        wait_left--;
      end
      if (wait_left == 0) begin
        pready <= 1'b1;
        prdata <= apb_read(paddr);
      end
    end
  end

  initial begin
    reset = 1'b1;
    raddr = '0;
    rvalid = 1'b0;
    rop = op_lw;
    waddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wop = op_sw;
    flush_pipe = 1'b0;
    invalid_l1d = 1'b0;
    prdata = '0;
    pready = 1'b0;
    cur_name = '0;
    exp_data = '0;
    exp_paddr = '0;
    exp_pstrb = '0;
    exp_reads = 0;
    exp_writes = 0;
    entry_end = 1'b0;
    all_done = 1'b0;
    rng = 32'h4646e531;
    n_entries = 0;
    build_table();
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < n_entries; i++) begin
      run_entry(stim[i]);
    end
    all_done <= 1'b1;
    @(posedge clock);
    all_done <= 1'b0;
    @(posedge clock);
    if (fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // generous budget per entry, a miss with full wait states needs about 14 cycles
  initial begin
    wait (n_entries > 0);
    repeat (reset_cycles + n_entries * 40) @(posedge clock);
    $display("watchdog expired, the DUT stopped answering requests");
    $display("TEST FAIL");
    $finish;
  end
endmodule

/* lsu_top.f */
hdl/lsu_pkg.sv
hdl/soc_map_pkg.sv
hdl/lsu_bus_if.sv
hdl/lsu_l1d.sv
hdl/lsu_store.sv
hdl/lsu_load_align.sv
hdl/lsu_apb_bridge.sv
hdl/lsu_top.sv
dv/lsu_checker.sv
dv/lsu_tb.sv
